// File: compile.f
+incdir+design
design/cps_mem_pkg.sv
design/cps_rom_loader.sv
design/cps_slot_mux.sv
design/cps_mem_top.sv
test/cps_sdram_model.sv
test/cps_mem_assertions.sv
test/cps_mem_tb.sv

// File: design/cps_mem_consts.svh
// Shared constants for the CPS memory side
// Offsets are SDRAM word addresses, download boundaries are byte addresses
// Region sizes are not checked, a ROM set larger than its region
// overlaps the next one in SDRAM
`ifndef CPS_MEM_CONSTS_SVH
`define CPS_MEM_CONSTS_SVH

// Bus widths
`define CPS_ADDR_W 22
`define CPS_DATA_W 16
`define CPS_READ_W 32

// Client slots on the SDRAM port
`define CPS_SLOTS 4

// Word offsets inside each bank
`define CPS_CPU_OFFSET   22'h00_0000
`define CPS_SND_OFFSET   22'h00_0000
`define CPS_ADPCM_OFFSET 22'h01_0000
`define CPS_RAM_OFFSET   22'h20_0000
`define CPS_VRAM_OFFSET  22'h30_0000
`define CPS_GFX_OFFSET   22'h00_0000

// Download byte boundaries, CPU ROM sits below the sound start
`define CPS_SND_START   25'h040_0000
`define CPS_ADPCM_START 25'h041_0000
`define CPS_GFX_START   25'h045_0000

// Banks
`define CPS_BANK_CPU 2'd1
`define CPS_BANK_SND 2'd0
`define CPS_BANK_GFX 2'd2

`endif

// File: design/cps_mem_pkg.sv
// Types shared by the loader, the slot multiplexer and the top level
// Field widths come from the constants header
`include "cps_mem_consts.svh"

package cps_mem_pkg;

    // Slot multiplexer FSM
    typedef enum logic [1:0] {
        MUX_IDLE,
        MUX_REQ,
        MUX_WAIT,
        MUX_DONE
    } mux_state_t;

    // Download writer FSM
    typedef enum logic {
        LOAD_IDLE,
        LOAD_WRITE
    } load_state_t;

    // Download regions in byte address order
    typedef enum logic [1:0] {
        REGION_CPU,
        REGION_SND,
        REGION_ADPCM,
        REGION_GFX
    } load_region_t;

    // One client request, wrmask is active low
    typedef struct packed {
        logic                   cs;
        logic                   we;
        logic                   vram;
        logic [`CPS_ADDR_W-1:0] addr;
        logic [`CPS_DATA_W-1:0] din;
        logic [1:0]             wrmask;
    } slot_req_t;

    // Command towards the SDRAM controller
    typedef struct packed {
        logic                   req;
        logic [`CPS_ADDR_W-1:0] addr;
        logic [1:0]             bank;
        logic                   rnw;
        logic [1:0]             wrmask;
        logic [`CPS_DATA_W-1:0] data;
    } sdram_cmd_t;

    // One byte write from the ROM download
    typedef struct packed {
        logic                   we;
        logic [`CPS_ADDR_W-1:0] addr;
        logic [7:0]             data;
        logic [1:0]             mask;
        logic [1:0]             bank;
    } prog_wr_t;

endpackage

// File: design/cps_mem_top.sv
// Memory side of the arcade board
// The ROM download writer and the slot multiplexer share one sdram_ack,
// the environment acknowledges prog_wr during download and sdram_cmd
// otherwise
// No latency is added on top of the two blocks
`include "cps_mem_consts.svh"

module cps_mem_top import cps_mem_pkg::*; (
    input  logic                          VB,
    input  logic                          rst,
    input  logic                          downloading,
    // ROM download
    input  logic [24:0]                   ioctl_addr,
    input  logic [7:0]                    ioctl_data,
    input  logic                          ioctl_wr,
    // Clients
    input  slot_req_t [`CPS_SLOTS-1:0]    slots,
    // SDRAM controller
    input  logic                          sdram_ack,
    input  logic                          data_rdy,
    input  logic [`CPS_READ_W-1:0]        data_read,
    output prog_wr_t                      prog_wr,
    output sdram_cmd_t                    sdram_cmd,
    output logic [`CPS_SLOTS-1:0]         slot_ok,
    output logic [`CPS_READ_W-1:0]        slot_dout
);

    cps_rom_loader loader_i (
        .VB          (VB),
        .rst         (rst),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_wr     (prog_wr)
    );

    // Client side and command side of the SDRAM port
    cps_slot_mux mux_i (
        .VB          (VB),
        .rst         (rst),
        .downloading (downloading),
        .slots       (slots),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .sdram_cmd   (sdram_cmd),
        .slot_ok     (slot_ok),
        .slot_dout   (slot_dout)
    );

endmodule

// File: design/cps_rom_loader.sv
// ROM download writer
// The loader must not issue ioctl_wr again before prog_wr.we has dropped,
// a byte arriving during a pending write is lost
// Bytes seen while downloading is low are ignored
`include "cps_mem_consts.svh"

module cps_rom_loader import cps_mem_pkg::*; (
    input  logic        VB,
    input  logic        rst,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output prog_wr_t    prog_wr
);

    load_state_t            state;
    load_region_t           region;
    logic [24:0]            region_start;
    logic [`CPS_ADDR_W-1:0] region_offset;
    logic [1:0]             region_bank;
    logic [24:0]            rel_addr;
    logic                   start_wr;
    logic [`CPS_ADDR_W-1:0] addr_q;
    logic [7:0]             data_q;
    logic [1:0]             mask_q;
    logic [1:0]             bank_q;

    // Highest boundary first
    always_comb begin
        if (ioctl_addr >= `CPS_GFX_START) begin
            region = REGION_GFX;
        end else if (ioctl_addr >= `CPS_ADPCM_START) begin
            region = REGION_ADPCM;
        end else if (ioctl_addr >= `CPS_SND_START) begin
            region = REGION_SND;
        end else begin
            region = REGION_CPU;
        end
    end

    always_comb begin
        case (region)
            REGION_SND: begin
                region_start  = `CPS_SND_START;
                region_offset = `CPS_SND_OFFSET;
                region_bank   = `CPS_BANK_SND;
            end
            REGION_ADPCM: begin
                region_start  = `CPS_ADPCM_START;
                region_offset = `CPS_ADPCM_OFFSET;
                region_bank   = `CPS_BANK_SND;
            end
            REGION_GFX: begin
                region_start  = `CPS_GFX_START;
                region_offset = `CPS_GFX_OFFSET;
                region_bank   = `CPS_BANK_GFX;
            end
            default: begin
                region_start  = 25'd0;
                region_offset = `CPS_CPU_OFFSET;
                region_bank   = `CPS_BANK_CPU;
            end
        endcase
    end

    assign rel_addr = ioctl_addr - region_start;
    assign start_wr = (state == LOAD_IDLE) && downloading && ioctl_wr;

    always_ff @(posedge VB) begin
        if (rst) begin
            state <= LOAD_IDLE;
        end else if (start_wr) begin
            state <= LOAD_WRITE;
        end else if (state == LOAD_WRITE && sdram_ack) begin
            state <= LOAD_IDLE;
        end
    end

    // Payload, region starts are even so bit 0 gives the byte lane
    always_ff @(posedge VB) begin
        if (start_wr) begin
            addr_q <= rel_addr[`CPS_ADDR_W:1] + region_offset;
            data_q <= ioctl_data;
            mask_q <= ioctl_addr[0] ? 2'b01 : 2'b10;
            bank_q <= region_bank;
        end
    end

    always_comb begin
        prog_wr.we   = (state == LOAD_WRITE);
        prog_wr.addr = addr_q;
        prog_wr.data = data_q;
        prog_wr.mask = mask_q;
        prog_wr.bank = bank_q;
    end

endmodule

// File: design/cps_slot_mux.sv
// SDRAM slot multiplexer for four clients
// Slot 0 CPU ROM, 1 RAM/VRAM, 2 graphics ROM, 3 sound ROM
// Fixed priority with the lowest index first, one access in flight
// Clients hold cs and their fields until slot_ok, only slot 1 may write
// No new grant is made while downloading
`include "cps_mem_consts.svh"

module cps_slot_mux import cps_mem_pkg::*; (
    input  logic                          VB,
    input  logic                          rst,
    input  logic                          downloading,
    input  slot_req_t [`CPS_SLOTS-1:0]    slots,
    input  logic                          sdram_ack,
    input  logic                          data_rdy,
    input  logic [`CPS_READ_W-1:0]        data_read,
    output sdram_cmd_t                    sdram_cmd,
    output logic [`CPS_SLOTS-1:0]         slot_ok,
    output logic [`CPS_READ_W-1:0]        slot_dout
);

    localparam int IDX_W = $clog2(`CPS_SLOTS);

    mux_state_t             state;
    logic [`CPS_SLOTS-1:0]  cs_vec;
    logic                   grant_any;
    logic [IDX_W-1:0]       grant_idx;
    logic [IDX_W-1:0]       sel;
    slot_req_t              granted;
    logic [`CPS_ADDR_W-1:0] cmd_addr;
    logic [1:0]             cmd_bank;
    logic                   cmd_rnw;
    logic [1:0]             cmd_wrmask;
    logic [`CPS_DATA_W-1:0] cmd_data;

    function automatic logic [`CPS_ADDR_W-1:0] slot_offset(
        input logic [IDX_W-1:0] idx,
        input logic             vram
    );
        case (idx)
            2'd0:    slot_offset = `CPS_CPU_OFFSET;
            2'd1:    slot_offset = vram ? `CPS_VRAM_OFFSET : `CPS_RAM_OFFSET;
            2'd2:    slot_offset = `CPS_GFX_OFFSET;
            default: slot_offset = `CPS_SND_OFFSET;
        endcase
    endfunction

    // RAM/VRAM and sound share bank 0
    function automatic logic [1:0] slot_bank(input logic [IDX_W-1:0] idx);
        case (idx)
            2'd0:    slot_bank = `CPS_BANK_CPU;
            2'd2:    slot_bank = `CPS_BANK_GFX;
            default: slot_bank = `CPS_BANK_SND;
        endcase
    endfunction

    // Lowest index wins, so scan from the top down
    always_comb begin
        for (int i = 0; i < `CPS_SLOTS; i++) begin
            cs_vec[i] = slots[i].cs;
        end
        grant_idx = '0;
        for (int i = `CPS_SLOTS - 1; i >= 0; i--) begin
            if (cs_vec[i]) begin
                grant_idx = IDX_W'(i);
            end
        end
    end

    assign grant_any = |cs_vec;
    assign granted   = slots[grant_idx];

    always_ff @(posedge VB) begin
        if (rst) begin
            state <= MUX_IDLE;
        end else begin
            case (state)
                MUX_IDLE: begin
                    if (grant_any && !downloading) begin
                        state <= MUX_REQ;
                    end
                end
                MUX_REQ: begin
                    if (sdram_ack) begin
                        state <= MUX_WAIT;
                    end
                end
                MUX_WAIT: begin
                    if (data_rdy) begin
                        state <= MUX_DONE;
                    end
                end
                default: state <= MUX_IDLE;
            endcase
        end
    end

    // Command fields latched at grant time
    always_ff @(posedge VB) begin
        if (state == MUX_IDLE && grant_any && !downloading) begin
            sel        <= grant_idx;
            cmd_addr   <= granted.addr + slot_offset(grant_idx, granted.vram);
            cmd_bank   <= slot_bank(grant_idx);
            cmd_rnw    <= !(granted.we && grant_idx == 2'd1);
            cmd_wrmask <= granted.wrmask;
            cmd_data   <= granted.din;
        end
    end

    // Write completion also captures the bus, the client ignores it
    always_ff @(posedge VB) begin
        if (state == MUX_WAIT && data_rdy) begin
            slot_dout <= data_read;
        end
    end

    always_comb begin
        sdram_cmd.req    = (state == MUX_REQ);
        sdram_cmd.addr   = cmd_addr;
        sdram_cmd.bank   = cmd_bank;
        sdram_cmd.rnw    = cmd_rnw;
        sdram_cmd.wrmask = cmd_wrmask;
        sdram_cmd.data   = cmd_data;
    end

    always_comb begin
        slot_ok = '0;
        if (state == MUX_DONE) begin
            slot_ok[sel] = 1'b1;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the memory side testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module cps_mem_tb -f compile.f -o cps_mem_sim
./obj_dir/cps_mem_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: test/cps_mem_assertions.sv
// Handshake checks on the memory side top level
// All checks are off while rst is high
`include "cps_mem_consts.svh"

module cps_mem_assertions import cps_mem_pkg::*; (
    input logic                  VB,
    input logic                  rst,
    input logic                  sdram_ack,
    input sdram_cmd_t            sdram_cmd,
    input prog_wr_t              prog_wr,
    input logic [`CPS_SLOTS-1:0] slot_ok
);

    int unsigned fail_count = 0;

    // req holds until the SDRAM side acknowledges
    req_held: assert property (@(posedge VB) disable iff (rst)
        sdram_cmd.req && !sdram_ack |=> sdram_cmd.req)
        else begin
            $error("sdram_cmd.req dropped before sdram_ack");
            fail_count++;
        end

    ok_single: assert property (@(posedge VB) disable iff (rst) $onehot0(slot_ok))
        else begin
            $error("more than one slot_ok bit high");
            fail_count++;
        end

    // Shared ack, so the two writers never overlap
    no_overlap: assert property (@(posedge VB) disable iff (rst)
        !(prog_wr.we && sdram_cmd.req))
        else begin
            $error("prog_wr.we and sdram_cmd.req high together");
            fail_count++;
        end

endmodule

bind cps_mem_top cps_mem_assertions assert_i (
    .VB        (VB),
    .rst       (rst),
    .sdram_ack (sdram_ack),
    .sdram_cmd (sdram_cmd),
    .prog_wr   (prog_wr),
    .slot_ok   (slot_ok)
);

// File: test/cps_mem_tb.sv
// Directed testbench for the memory side top level
// Expected memory contents live in a shadow of the SDRAM model
// Unwritten words follow the same fill rule as the model
// Stops at the first mismatch
`include "cps_mem_consts.svh"

module cps_mem_tb import cps_mem_pkg::*;;

    // About 250 cycles of tests plus a wide margin
    localparam int MAX_CYCLES = 2000;

    logic                        VB;
    logic                        rst;
    logic                        downloading;
    logic [24:0]                 ioctl_addr;
    logic [7:0]                  ioctl_data;
    logic                        ioctl_wr;
    slot_req_t [`CPS_SLOTS-1:0]  slots;
    logic                        sdram_ack;
    logic                        data_rdy;
    logic [`CPS_READ_W-1:0]      data_read;
    prog_wr_t                    prog_wr;
    sdram_cmd_t                  sdram_cmd;
    logic [`CPS_SLOTS-1:0]       slot_ok;
    logic [`CPS_READ_W-1:0]      slot_dout;
    logic [2:0]                  rd_delay;
    logic [31:0]                 lfsr_state = 32'd79270;
    logic [31:0]                 shadow [logic [23:0]];
    int                          cycles = 0;

    cps_mem_top dut_i (
        .VB(VB), .rst(rst), .downloading(downloading), .ioctl_addr(ioctl_addr),
        .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr), .slots(slots),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read),
        .prog_wr(prog_wr), .sdram_cmd(sdram_cmd), .slot_ok(slot_ok), .slot_dout(slot_dout)
    );

    cps_sdram_model model_i (
        .VB(VB), .rst(rst), .prog_wr(prog_wr), .sdram_cmd(sdram_cmd), .delay(rd_delay),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read)
    );

    initial begin
        VB = 1'b0;
        forever #5 VB = ~VB;
    end

    always @(posedge VB) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) report_fail("timeout, the tests did not finish in time");
        if (dut_i.assert_i.fail_count != 0) report_fail("a handshake assertion failed");
    end

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic next_cycle();
        @(posedge VB);
        #1;
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hD000_0001 : lfsr_state >> 1;
        end
        return r;
    endfunction

    task automatic check_prog(input string name, input prog_wr_t exp, input prog_wr_t act);
        if (exp !== act) report_fail($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_cmd(input string name, input sdram_cmd_t exp, input sdram_cmd_t act);
        if (exp !== act) report_fail($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) report_fail($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bits(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act) report_fail($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    function automatic logic [31:0] expected_word(input logic [1:0] bank, input logic [21:0] addr);
        if (shadow.exists({bank, addr})) return shadow[{bank, addr}];
        return {bank, addr, addr[7:0]};
    endfunction

    task automatic shadow_write(input logic [1:0] bank, input logic [21:0] addr,
                                input logic [15:0] d, input logic [1:0] mask);
        logic [31:0] w;
        w = expected_word(bank, addr);
        if (!mask[0]) w[7:0] = d[7:0];
        if (!mask[1]) w[15:8] = d[15:8];
        shadow[{bank, addr}] = w;
    endtask

    // Slot order is CPU ROM, RAM/VRAM, graphics, sound
    function automatic logic [21:0] offset_for(input int idx, input logic vram);
        case (idx)
            0: return `CPS_CPU_OFFSET;
            1: return vram ? `CPS_VRAM_OFFSET : `CPS_RAM_OFFSET;
            2: return `CPS_GFX_OFFSET;
            default: return `CPS_SND_OFFSET;
        endcase
    endfunction

    function automatic logic [1:0] bank_for(input int idx);
        case (idx)
            0: return 2'd1;
            2: return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    task automatic load_byte(input string name, input logic [24:0] addr, input logic [7:0] data,
                             input logic [24:0] start, input logic [21:0] offset,
                             input logic [1:0] bank);
        prog_wr_t exp;
        exp.we   = 1'b1;
        exp.addr = 22'((addr - start) >> 1) + offset;
        exp.data = data;
        exp.mask = addr[0] ? 2'b01 : 2'b10;
        exp.bank = bank;
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        next_cycle();
        ioctl_wr = 1'b0;
        check_prog(name, exp, prog_wr);
        shadow_write(exp.bank, exp.addr, {data, data}, exp.mask);
        while (prog_wr.we) next_cycle();
    endtask

    // One even and one odd byte of the same word
    task automatic load_region(input string name, input logic [24:0] start,
                               input logic [21:0] offset, input logic [1:0] bank);
        logic [24:0] addr;
        addr = start + {9'd0, 15'(rand_bits(15)), 1'b0};
        load_byte({name, " even"}, addr, 8'(rand_bits(8)), start, offset, bank);
        load_byte({name, " odd"}, addr + 25'd1, 8'(rand_bits(8)), start, offset, bank);
    endtask

    task automatic raise_cs(input int idx, input logic we, input logic vram,
                            input logic [21:0] addr, input logic [15:0] din,
                            input logic [1:0] wrmask);
        slots[idx].we     = we;
        slots[idx].vram   = vram;
        slots[idx].addr   = addr;
        slots[idx].din    = din;
        slots[idx].wrmask = wrmask;
        slots[idx].cs     = 1'b1;
        rd_delay = 3'd1 + 3'(rand_bits(2));
    endtask

    // Waits for the command and slot_ok of one held request
    task automatic serve(input string name, input int idx);
        sdram_cmd_t exp;
        exp.req    = 1'b1;
        exp.addr   = slots[idx].addr + offset_for(idx, slots[idx].vram);
        exp.bank   = bank_for(idx);
        exp.rnw    = !slots[idx].we;
        exp.wrmask = slots[idx].wrmask;
        exp.data   = slots[idx].din;
        while (!sdram_cmd.req) next_cycle();
        check_cmd(name, exp, sdram_cmd);
        while (!slot_ok[idx]) next_cycle();
        check_bits({name, " ok"}, 4'b0001 << idx, slot_ok);
        if (slots[idx].we) begin
            shadow_write(exp.bank, exp.addr, exp.data, exp.wrmask);
        end else begin
            check_word(name, expected_word(exp.bank, exp.addr), slot_dout);
        end
        next_cycle();
        slots[idx].cs = 1'b0;
    endtask

    task automatic access(input string name, input int idx, input logic we, input logic vram,
                          input logic [21:0] addr, input logic [15:0] din,
                          input logic [1:0] wrmask);
        raise_cs(idx, we, vram, addr, din, wrmask);
        serve(name, idx);
    endtask

    task automatic test_idle();
        repeat (8) begin
            check_bits("idle req", 4'd0, {3'd0, sdram_cmd.req});
            check_bits("idle slot_ok", 4'd0, slot_ok);
            check_bits("idle we", 4'd0, {3'd0, prog_wr.we});
            next_cycle();
        end
    endtask

    task automatic test_download();
        downloading = 1'b1;
        load_region("load cpu", 25'd0, `CPS_CPU_OFFSET, 2'd1);
        load_region("load snd", `CPS_SND_START, `CPS_SND_OFFSET, 2'd0);
        load_region("load adpcm", `CPS_ADPCM_START, `CPS_ADPCM_OFFSET, 2'd0);
        load_region("load gfx", `CPS_GFX_START, `CPS_GFX_OFFSET, 2'd2);
        downloading = 1'b0;
        next_cycle();
    endtask

    task automatic test_rom_reads();
        access("cpu read a", 0, 1'b0, 1'b0, 22'(rand_bits(18)), 16'd0, 2'b11);
        access("cpu read b", 0, 1'b0, 1'b0, 22'(rand_bits(18)), 16'd0, 2'b11);
        access("gfx read a", 2, 1'b0, 1'b0, 22'(rand_bits(20)), 16'd0, 2'b11);
        access("gfx read b", 2, 1'b0, 1'b0, 22'(rand_bits(20)), 16'd0, 2'b11);
    endtask

    // Same client address under RAM and VRAM with byte masks merged
    task automatic test_ram_vram();
        logic [21:0] addr;
        addr = 22'(rand_bits(16));
        access("ram write", 1, 1'b1, 1'b0, addr, 16'(rand_bits(16)), 2'b00);
        access("vram write", 1, 1'b1, 1'b1, addr, 16'(rand_bits(16)), 2'b00);
        access("ram write high", 1, 1'b1, 1'b0, addr, 16'(rand_bits(16)), 2'b01);
        access("vram write low", 1, 1'b1, 1'b1, addr, 16'(rand_bits(16)), 2'b10);
        access("ram read", 1, 1'b0, 1'b0, addr, 16'd0, 2'b11);
        access("vram read", 1, 1'b0, 1'b1, addr, 16'd0, 2'b11);
    endtask

    task automatic test_priority();
        raise_cs(3, 1'b0, 1'b0, 22'(rand_bits(16)), 16'd0, 2'b11);
        raise_cs(2, 1'b0, 1'b0, 22'(rand_bits(16)), 16'd0, 2'b11);
        serve("prio gfx first", 2);
        serve("prio snd second", 3);
        raise_cs(1, 1'b0, 1'b0, 22'(rand_bits(16)), 16'd0, 2'b11);
        raise_cs(0, 1'b0, 1'b0, 22'(rand_bits(16)), 16'd0, 2'b11);
        serve("prio cpu first", 0);
        serve("prio ram second", 1);
    endtask

    task automatic test_download_block();
        downloading = 1'b1;
        raise_cs(0, 1'b0, 1'b0, 22'(rand_bits(18)), 16'd0, 2'b11);
        repeat (10) begin
            next_cycle();
            check_bits("blocked req", 4'd0, {3'd0, sdram_cmd.req});
        end
        downloading = 1'b0;
        serve("after download", 0);
    endtask

    initial begin
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        slots       = '0;
        rd_delay    = 3'd1;
        repeat (4) @(posedge VB);
        #1;
        rst = 1'b0;
        test_idle();
        test_download();
        test_rom_reads();
        test_ram_vram();
        test_priority();
        test_download_block();
        if (dut_i.assert_i.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_fail("a handshake assertion failed");
        end
    end

endmodule

// File: test/cps_sdram_model.sv
// Behavioral SDRAM responder for the memory side testbench
// One access at a time
// Ack comes one cycle after req or we is seen
// Storage keyed by {bank, word address}
// Masks are active low
// Unwritten words read back as {bank, addr, addr[7:0]}
`include "cps_mem_consts.svh"

module cps_sdram_model import cps_mem_pkg::*; (
    input  logic                   VB,
    input  logic                   rst,
    input  prog_wr_t               prog_wr,
    input  sdram_cmd_t             sdram_cmd,
    input  logic [2:0]             delay,
    output logic                   sdram_ack,
    output logic                   data_rdy,
    output logic [`CPS_READ_W-1:0] data_read
);

    logic [31:0] mem [logic [23:0]];
    logic [31:0] rd_word;
    logic        pending;
    logic [2:0]  count;

    function automatic logic [31:0] blank_word(input logic [23:0] key);
        return {key, key[7:0]};
    endfunction

    task automatic store(input logic [23:0] key, input logic [15:0] d, input logic [1:0] mask);
        logic [31:0] w;
        w = mem.exists(key) ? mem[key] : blank_word(key);
        if (!mask[0]) w[7:0] = d[7:0];
        if (!mask[1]) w[15:8] = d[15:8];
        mem[key] = w;
    endtask

    always @(posedge VB) begin
        data_rdy <= 1'b0;
        if (rst) begin
            sdram_ack <= 1'b0;
            pending   <= 1'b0;
            count     <= 3'd0;
            data_read <= '0;
        end else begin
            sdram_ack <= 1'b0;
            if (!sdram_ack && prog_wr.we) begin
                sdram_ack <= 1'b1;
                store({prog_wr.bank, prog_wr.addr}, {2{prog_wr.data}}, prog_wr.mask);
            end else if (!sdram_ack && sdram_cmd.req) begin
                sdram_ack <= 1'b1;
                pending   <= 1'b1;
                count     <= delay;
                if (!sdram_cmd.rnw) begin
                    store({sdram_cmd.bank, sdram_cmd.addr}, sdram_cmd.data, sdram_cmd.wrmask);
                end else if (mem.exists({sdram_cmd.bank, sdram_cmd.addr})) begin
                    rd_word <= mem[{sdram_cmd.bank, sdram_cmd.addr}];
                end else begin
                    rd_word <= blank_word({sdram_cmd.bank, sdram_cmd.addr});
                end
            end else if (pending) begin
                // Completion strobe for reads and writes
                if (count <= 3'd1) begin
                    data_rdy  <= 1'b1;
                    data_read <= rd_word;
                    pending   <= 1'b0;
                end else begin
                    count <= count - 3'd1;
                end
            end
        end
    end

endmodule
